/* include/issue_settings.svh */
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Data path word
`define ISSUE_DATA_W 16

// ROB entry tag for eight entries
`define ISSUE_TAG_W 3

// Architectural register index
`define ISSUE_REG_W 3

// ALU reservation stations
`define ISSUE_NUM_ALU_RS 3

`endif

/* hdl/issue_pkg.sv */
`include "issue_settings.svh"

package issue_pkg;

	localparam int RS_IDX_W = $clog2(`ISSUE_NUM_ALU_RS);

	typedef logic [`ISSUE_DATA_W-1:0] word_t;
	typedef logic [`ISSUE_TAG_W-1:0] tag_t;
	typedef logic [`ISSUE_REG_W-1:0] reg_idx_t;
	typedef logic [RS_IDX_W-1:0] rs_idx_t;

	// LC-3b opcodes from instr[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} opcode_e;

	typedef struct packed {
		word_t instr;
		word_t pc; // Already incremented
		logic  predict;
	} fetch_t;

	typedef struct packed {
		logic  busy;
		tag_t  tag; // Producer ROB entry
		word_t data;
	} reg_status_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} cdb_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} rob_read_t;

	// Either ready with value, or waiting on tag
	typedef struct packed {
		logic  ready;
		tag_t  tag;
		word_t value;
	} operand_t;

	typedef struct packed {
		opcode_e  opcode;
		rs_idx_t  station;
		operand_t j;
		operand_t k;
		tag_t     dest;
	} alu_issue_t;

	typedef struct packed {
		opcode_e  opcode;
		logic     store;
		operand_t base;
		operand_t src;
		word_t    offset;
		tag_t     dest; // Zero for stores
	} ldst_issue_t;

	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t dest;
		word_t    value;
		logic     writes_reg;
	} rob_entry_t;

	typedef struct packed {
		reg_idx_t dest;
		tag_t     tag;
	} rename_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t dest;
		logic     alu;
		logic     mem;
		logic     store;
		logic     branch;
		logic     lea;
		logic     use_imm;
		word_t    imm5;
		word_t    offset6;
		word_t    target;
	} decode_t;

endpackage

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module instr_decoder
(
	input  issue_pkg::fetch_t           fetch,
	output issue_pkg::decode_t          dec,
	output logic [`ISSUE_REG_W-1:0]     rd_idx1,
	output logic [`ISSUE_REG_W-1:0]     rd_idx2
);

	import issue_pkg::*;

	word_t    instr;
	opcode_e  opcode;
	reg_idx_t dest_f;
	reg_idx_t sr1_f;
	reg_idx_t sr2_f;
	word_t    off9_adj;

	assign instr  = fetch.instr;
	assign opcode = opcode_e'(instr[15:12]);
	assign dest_f = instr[11:9];
	assign sr1_f  = instr[8:6];
	assign sr2_f  = instr[2:0];

	// PCoffset9 sign extended and word aligned
	assign off9_adj = {{(`ISSUE_DATA_W-10){instr[8]}}, instr[8:0], 1'b0};

	// Class flags
	always_comb
	begin
		dec.alu    = 1'b0;
		dec.mem    = 1'b0;
		dec.store  = 1'b0;
		dec.branch = 1'b0;
		dec.lea    = 1'b0;
		case (opcode)
			op_add, op_and, op_not:
			begin
				dec.alu = 1'b1;
			end
			op_ldr:
			begin
				dec.mem = 1'b1;
			end
			op_str:
			begin
				dec.mem   = 1'b1;
				dec.store = 1'b1;
			end
			op_br:
			begin
				dec.branch = 1'b1;
			end
			op_lea:
			begin
				dec.lea = 1'b1;
			end
			default:
			begin
				dec.alu = 1'b0; // Not issued by this stage
			end
		endcase
	end

	assign dec.opcode = opcode;
	assign dec.dest   = dest_f;

	// Bit 5 selects imm5; NOT has it set with all ones
	assign dec.use_imm = dec.alu & instr[5];

	assign dec.imm5    = {{(`ISSUE_DATA_W-5){instr[4]}}, instr[4:0]};
	assign dec.offset6 = {{(`ISSUE_DATA_W-7){instr[5]}}, instr[5:0], 1'b0};
	assign dec.target  = fetch.pc + off9_adj;

	// STR reads its source through the second port
	assign rd_idx1 = sr1_f;
	assign rd_idx2 = dec.store ? dest_f : sr2_f;

endmodule

/* hdl/operand_resolver.sv */
`timescale 1ns/10ps

module operand_resolver
(
	input  issue_pkg::reg_status_t status,
	input  issue_pkg::cdb_t        cdb,
	input  issue_pkg::rob_read_t   rob,
	output issue_pkg::operand_t    opnd
);

	logic cdb_hit;

	// Producer broadcasting right now
	assign cdb_hit = cdb.valid && (cdb.tag == status.tag);

	always_comb
	begin
		opnd = '0;
		if (!status.busy)
		begin
			opnd.ready = 1'b1; // Committed value in register file
			opnd.value = status.data;
		end
		else if (cdb_hit)
		begin
			opnd.ready = 1'b1;
			opnd.value = cdb.data;
		end
		else if (rob.valid)
		begin
			// Finished but not yet committed
			opnd.ready = 1'b1;
			opnd.value = rob.data;
		end
		else
		begin
			opnd.ready = 1'b0;
			opnd.tag   = status.tag; // Wait on producer
		end
	end

endmodule

/* hdl/issue_control.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_control
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           flush,
	input  logic                           instr_valid,
	input  issue_pkg::decode_t             dec,
	input  logic [`ISSUE_DATA_W-1:0]       pc,
	input  logic                           predict,
	input  issue_pkg::operand_t            opnd1,
	input  issue_pkg::operand_t            opnd2,
	input  logic [`ISSUE_NUM_ALU_RS-1:0]   alu_busy,
	input  logic                           ldst_full,
	input  logic                           rob_full,
	input  logic [`ISSUE_TAG_W-1:0]        rob_tail,
	output logic                           stall,
	output issue_pkg::redirect_t           redirect,
	output logic                           alu_we,
	output issue_pkg::alu_issue_t          alu_pkt,
	output logic                           ldst_we,
	output issue_pkg::ldst_issue_t         ldst_pkt,
	output logic                           rob_we,
	output issue_pkg::rob_entry_t          rob_pkt,
	output logic                           rename_we,
	output issue_pkg::rename_t             rename_pkt
);

	import issue_pkg::*;

	logic     bubble; // Slot after a predicted-taken branch
	logic     hazard;
	logic     issue;
	logic     known_op;
	logic     writes_reg;
	logic     br_taken;
	rs_idx_t  free_rs;
	operand_t imm_opnd;

	// Structural hazards
	assign hazard = rob_full
		| (dec.alu & (&alu_busy))
		| (dec.mem & ldst_full);

	// Dropped slot neither stalls nor issues
	assign stall = instr_valid & ~bubble & hazard;
	assign issue = instr_valid & ~bubble & ~hazard;

	assign known_op   = dec.alu | dec.mem | dec.branch | dec.lea;
	assign writes_reg = dec.alu | (dec.mem & ~dec.store) | dec.lea;
	assign br_taken   = issue & dec.branch & predict;

	always_ff @(posedge clk)
	begin
		if (rst || flush)
			bubble <= 1'b0;
		else
			bubble <= br_taken; // Self clears as nothing issues in the bubble slot
	end

	// Lowest-numbered free station wins
	always_comb
	begin
		free_rs = '0;
		for (int i = `ISSUE_NUM_ALU_RS - 1; i >= 0; i--)
		begin
			if (!alu_busy[i])
				free_rs = rs_idx_t'(i);
		end
	end

	always_comb
	begin
		imm_opnd       = '0;
		imm_opnd.ready = 1'b1;
		imm_opnd.value = dec.imm5;
	end

	// Write strobes
	assign alu_we    = issue & dec.alu;
	assign ldst_we   = issue & dec.mem;
	assign rob_we    = issue & known_op;
	assign rename_we = issue & writes_reg;

	assign redirect.taken  = br_taken;
	assign redirect.target = dec.target;

	// ALU station packet
	always_comb
	begin
		alu_pkt.opcode  = dec.opcode;
		alu_pkt.station = free_rs;
		alu_pkt.j       = opnd1;
		alu_pkt.k       = dec.use_imm ? imm_opnd : opnd2;
		alu_pkt.dest    = rob_tail;
	end

	// Load/store buffer packet
	always_comb
	begin
		ldst_pkt.opcode = dec.opcode;
		ldst_pkt.store  = dec.store;
		ldst_pkt.base   = opnd1;
		ldst_pkt.src    = opnd2;
		ldst_pkt.offset = dec.offset6;
		ldst_pkt.dest   = dec.store ? '0 : rob_tail;
		if (!dec.store)
		begin
			ldst_pkt.src       = '0; // Loads carry no store data
			ldst_pkt.src.ready = 1'b1;
		end
	end

	// ROB entry
	always_comb
	begin
		rob_pkt.opcode     = dec.opcode;
		rob_pkt.dest       = writes_reg ? dec.dest : '0;
		rob_pkt.writes_reg = writes_reg;
		rob_pkt.value      = '0;
		if (dec.branch)
		begin
			// Predicted taken keeps the fall-through for recovery
			rob_pkt.value = predict ? pc : dec.target;
		end
		else if (dec.lea)
		begin
			rob_pkt.value = dec.target;
		end
	end

	assign rename_pkt.dest = dec.dest;
	assign rename_pkt.tag  = rob_tail; // New producer of dest

endmodule

/* hdl/issue_stage.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_stage
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           flush,
	input  issue_pkg::fetch_t              fetch,
	input  logic                           instr_valid,
	output logic                           stall,
	output issue_pkg::redirect_t           redirect,
	output logic [`ISSUE_REG_W-1:0]        rd_idx1,
	output logic [`ISSUE_REG_W-1:0]        rd_idx2,
	input  issue_pkg::reg_status_t         reg1,
	input  issue_pkg::reg_status_t         reg2,
	input  issue_pkg::cdb_t                cdb,
	output logic [`ISSUE_TAG_W-1:0]        rob_tag1,
	output logic [`ISSUE_TAG_W-1:0]        rob_tag2,
	input  issue_pkg::rob_read_t           rob1,
	input  issue_pkg::rob_read_t           rob2,
	input  logic                           rob_full,
	input  logic [`ISSUE_TAG_W-1:0]        rob_tail,
	input  logic [`ISSUE_NUM_ALU_RS-1:0]   alu_busy,
	input  logic                           ldst_full,
	output logic                           alu_we,
	output issue_pkg::alu_issue_t          alu_pkt,
	output logic                           ldst_we,
	output issue_pkg::ldst_issue_t         ldst_pkt,
	output logic                           rob_we,
	output issue_pkg::rob_entry_t          rob_pkt,
	output logic                           rename_we,
	output issue_pkg::rename_t             rename_pkt
);

	import issue_pkg::*;

	decode_t  dec;
	operand_t opnd1;
	operand_t opnd2;

	// ROB lookup by producer tag
	assign rob_tag1 = reg1.tag;
	assign rob_tag2 = reg2.tag;

	instr_decoder u_dec (
		.fetch   (fetch),
		.dec     (dec),
		.rd_idx1 (rd_idx1),
		.rd_idx2 (rd_idx2)
	);

	operand_resolver u_opnd1 (.status(reg1), .cdb(cdb), .rob(rob1), .opnd(opnd1));

	operand_resolver u_opnd2 (.status(reg2), .cdb(cdb), .rob(rob2), .opnd(opnd2));

	issue_control u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.instr_valid (instr_valid),
		.dec         (dec),
		.pc          (fetch.pc),
		.predict     (fetch.predict),
		.opnd1       (opnd1),
		.opnd2       (opnd2),
		.alu_busy    (alu_busy),
		.ldst_full   (ldst_full),
		.rob_full    (rob_full),
		.rob_tail    (rob_tail),
		.stall       (stall),
		.redirect    (redirect),
		.alu_we      (alu_we),
		.alu_pkt     (alu_pkt),
		.ldst_we     (ldst_we),
		.ldst_pkt    (ldst_pkt),
		.rob_we      (rob_we),
		.rob_pkt     (rob_pkt),
		.rename_we   (rename_we),
		.rename_pkt  (rename_pkt)
	);

endmodule

/* test/issue_asserts.sv */
`timescale 1ns/10ps

module issue_asserts
(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic taken,
	input logic alu_we,
	input logic ldst_we,
	input logic rob_we,
	input logic rename_we
);

	logic any_we;
	int   fail_count = 0;

	assign any_we = alu_we | ldst_we | rob_we | rename_we;

	a_quiet_on_stall: assert property (@(posedge clk) disable iff (rst) stall |-> !any_we)
		else
		begin
			fail_count++;
			$error("write strobe high while stalled");
		end

	a_one_queue: assert property (@(posedge clk) disable iff (rst) !(alu_we && ldst_we))
		else
		begin
			fail_count++;
			$error("ALU and load/store strobes high together");
		end

	// Slot after a predicted-taken branch is dropped
	a_bubble: assert property (@(posedge clk) disable iff (rst) taken |=> !any_we)
		else
		begin
			fail_count++;
			$error("write strobe high in the branch bubble slot");
		end

endmodule

bind issue_control issue_asserts u_asserts (
	.clk       (clk),
	.rst       (rst),
	.stall     (stall),
	.taken     (redirect.taken),
	.alu_we    (alu_we),
	.ldst_we   (ldst_we),
	.rob_we    (rob_we),
	.rename_we (rename_we)
);

/* test/tb_issue_stage.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module tb_issue_stage;

	import issue_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam word_t ADD_RR = {4'b0001, 3'd1, 3'd2, 3'b000, 3'd3}; // ADD R1, R2, R3
	localparam word_t LDR_OP = {4'b0110, 3'd1, 3'd2, 6'h04};

	logic clk, rst, flush, instr_valid, stall;
	logic alu_we, ldst_we, rob_we, rename_we;
	logic rob_full, ldst_full;
	logic [`ISSUE_NUM_ALU_RS-1:0] alu_busy;
	fetch_t fetch;
	redirect_t redirect;
	reg_idx_t rd_idx1, rd_idx2;
	reg_status_t reg1, reg2;
	cdb_t cdb;
	tag_t rob_tag1, rob_tag2, rob_tail;
	rob_read_t rob1, rob2;
	alu_issue_t alu_pkt;
	ldst_issue_t ldst_pkt;
	rob_entry_t rob_pkt;
	rename_t rename_pkt;
	int errors = 0;
	logic [31:0] lfsr = 32'hc7a2;

	issue_stage u_dut (.*);

	always #20 clk = ~clk;

	// Galois LFSR stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic operand_t ready_op(input word_t v);
		return {1'b1, {`ISSUE_TAG_W{1'b0}}, v};
	endfunction

	function automatic operand_t wait_op(input tag_t t);
		return {1'b0, t, {`ISSUE_DATA_W{1'b0}}};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			errors++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic check_strobes(input logic a, input logic l, input logic r, input logic n,
		input logic s);
		check("alu_we", a, alu_we);
		check("ldst_we", l, ldst_we);
		check("rob_we", r, rob_we);
		check("rename_we", n, rename_we);
		check("stall", s, stall);
	endtask

	// Fresh ready sources and no hazards
	task automatic setup_cycle;
		reg1 = '{1'b0, tag_t'(rand_bits(3)), rand_bits(16)};
		reg2 = '{1'b0, tag_t'(rand_bits(3)), rand_bits(16)};
		cdb = '0;
		rob1 = '0;
		rob2 = '0;
		rob_full = 1'b0;
		alu_busy = '0;
		ldst_full = 1'b0;
		rob_tail = tag_t'(rand_bits(3));
		fetch.pc = rand_bits(16);
		fetch.predict = 1'b0;
		instr_valid = 1'b1;
	endtask

	task automatic idle_outputs;
		for (int n = 0; n < 2; n++)
		begin
			@(negedge clk);
			setup_cycle();
			fetch.instr = {4'b0000, 3'b111, 9'h020};
			fetch.predict = 1'b1;
			rob_full = (n == 1); // A pending hazard must not raise stall
			instr_valid = 1'b0;
			@(posedge clk);
			check_strobes(0, 0, 0, 0, 0);
			check("redirect.taken", 0, redirect.taken);
		end
	endtask

	task automatic add_issue;
		int lowest;
		logic [4:0] imm;
		for (int n = 0; n < 6; n++)
		begin
			@(negedge clk);
			setup_cycle();
			alu_busy = `ISSUE_NUM_ALU_RS'(rand_bits(`ISSUE_NUM_ALU_RS));
			if (&alu_busy)
				alu_busy[`ISSUE_NUM_ALU_RS-1] = 1'b0;
			imm = 5'(rand_bits(5));
			fetch.instr = (n < 3) ? ADD_RR : {4'b0001, 3'd1, 3'd2, 1'b1, imm};
			lowest = 0;
			while (alu_busy[lowest])
				lowest++;
			@(posedge clk);
			check_strobes(1, 0, 1, 1, 0);
			check("rd_idx1", 2, rd_idx1);
			if (n < 3)
				check("rd_idx2", 3, rd_idx2);
			check("alu_pkt.opcode", 4'b0001, alu_pkt.opcode);
			check("alu_pkt.station", lowest, alu_pkt.station);
			check("alu_pkt.j", ready_op(reg1.data), alu_pkt.j);
			check("alu_pkt.k", ready_op((n < 3) ? reg2.data : word_t'(int'($signed(imm)))),
				alu_pkt.k);
			check("alu_pkt.dest", rob_tail, alu_pkt.dest);
			check("rob_pkt.opcode", 4'b0001, rob_pkt.opcode);
			check("rob_pkt.dest", 1, rob_pkt.dest);
			check("rob_pkt.writes_reg", 1, rob_pkt.writes_reg);
			check("rename_pkt.dest", 1, rename_pkt.dest);
			check("rename_pkt.tag", rob_tail, rename_pkt.tag);
		end
	endtask

	// n = 0 CDB hit, n = 1 ROB hit, n = 2 neither
	task automatic operand_priority;
		tag_t t;
		for (int n = 0; n < 3; n++)
		begin
			@(negedge clk);
			setup_cycle();
			t = tag_t'(rand_bits(3));
			reg1.busy = 1'b1;
			reg1.tag = t;
			reg2.busy = 1'b1;
			reg2.tag = t;
			cdb = '{1'b1, (n == 0) ? t : tag_t'(t + 1), rand_bits(16)};
			rob1 = '{(n < 2), rand_bits(16)};
			rob2 = '{(n < 2), rand_bits(16)};
			fetch.instr = ADD_RR;
			@(posedge clk);
			check("rob_tag1", t, rob_tag1);
			check("rob_tag2", t, rob_tag2);
			check("alu_pkt.j", (n == 0) ? ready_op(cdb.data) :
				(n == 1) ? ready_op(rob1.data) : wait_op(t), alu_pkt.j);
			check("alu_pkt.k", (n == 0) ? ready_op(cdb.data) :
				(n == 1) ? ready_op(rob2.data) : wait_op(t), alu_pkt.k);
		end
	endtask

	task automatic load_store;
		logic [5:0] off;
		for (int n = 0; n < 2; n++)
		begin
			@(negedge clk);
			setup_cycle();
			off = 6'(rand_bits(6));
			fetch.instr = {(n == 0) ? 4'b0110 : 4'b0111, 3'd6, 3'd4, off};
			@(posedge clk);
			check_strobes(0, 1, 1, (n == 0), 0);
			check("ldst_pkt.opcode", (n == 0) ? 4'b0110 : 4'b0111, ldst_pkt.opcode);
			check("ldst_pkt.offset", word_t'(2 * int'($signed(off))), ldst_pkt.offset);
			check("ldst_pkt.base", ready_op(reg1.data), ldst_pkt.base);
			check("ldst_pkt.store", n, ldst_pkt.store);
			check("ldst_pkt.dest", (n == 0) ? rob_tail : 0, ldst_pkt.dest);
			check("rob_pkt.writes_reg", (n == 0), rob_pkt.writes_reg);
			if (n == 0)
			begin
				check("rename_pkt.dest", 6, rename_pkt.dest);
				check("rename_pkt.tag", rob_tail, rename_pkt.tag);
			end
			else
			begin
				check("rd_idx2", 6, rd_idx2); // Store source field
				check("ldst_pkt.src", ready_op(reg2.data), ldst_pkt.src);
			end
		end
	endtask

	task automatic hazard_case(input word_t instr, input logic rfull,
		input logic [`ISSUE_NUM_ALU_RS-1:0] busy, input logic lfull, input logic exp_stall);
		@(negedge clk);
		setup_cycle();
		fetch.instr = instr;
		rob_full = rfull;
		alu_busy = busy;
		ldst_full = lfull;
		@(posedge clk);
		check("stall", exp_stall, stall);
		check("rob_we", !exp_stall, rob_we);
		check("alu_we|ldst_we", !exp_stall, alu_we | ldst_we);
	endtask

	task automatic back_pressure;
		hazard_case(ADD_RR, 1, 0, 0, 1);
		hazard_case(LDR_OP, 1, 0, 0, 1);
		hazard_case({4'b0000, 3'b111, 9'h010}, 1, 0, 0, 1);
		hazard_case(ADD_RR, 0, '1, 0, 1);
		hazard_case(LDR_OP, 0, '1, 0, 0);
		hazard_case(LDR_OP, 0, 0, 1, 1);
		hazard_case(ADD_RR, 0, 0, 1, 0);
		hazard_case(LDR_OP, 0, 0, 1, 1);
		hazard_case(LDR_OP, 0, 0, 0, 0); // Held load goes once the buffer frees
	endtask

	task automatic branch_and_lea;
		logic [8:0] off;
		word_t target;
		for (int n = 0; n < 3; n++)
		begin
			@(negedge clk);
			setup_cycle();
			off = 9'(rand_bits(9));
			fetch.instr = {(n == 2) ? 4'b1110 : 4'b0000, 3'b010, off};
			fetch.predict = (n == 1);
			target = word_t'(int'(fetch.pc) + 2 * int'($signed(off)));
			@(posedge clk);
			check_strobes(0, 0, 1, (n == 2), 0);
			check("redirect.taken", (n == 1), redirect.taken);
			check("rob_pkt.value", (n == 1) ? fetch.pc : target, rob_pkt.value);
			check("rob_pkt.writes_reg", (n == 2), rob_pkt.writes_reg);
			if (n == 1)
			begin
				check("redirect.target", target, redirect.target);
				@(negedge clk);
				setup_cycle();
				fetch.instr = ADD_RR;
				rob_full = 1'b1; // Dropped slot must not stall either
				@(posedge clk);
				check_strobes(0, 0, 0, 0, 0);
				@(negedge clk);
				rob_full = 1'b0;
				@(posedge clk);
				check_strobes(1, 0, 1, 1, 0);
			end
			if (n == 2)
			begin
				check("rename_pkt.dest", 2, rename_pkt.dest);
				check("rename_pkt.tag", rob_tail, rename_pkt.tag);
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		instr_valid = 1'b0;
		fetch = '0;
		reg1 = '0;
		reg2 = '0;
		cdb = '0;
		rob1 = '0;
		rob2 = '0;
		rob_full = 1'b0;
		rob_tail = '0;
		alu_busy = '0;
		ldst_full = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle_outputs();
		add_issue();
		operand_priority();
		load_store();
		back_pressure();
		branch_and_lea();
		@(negedge clk);
		instr_valid = 1'b0;
		$display("Errors: %0d, assertion failures: %0d", errors,
			u_dut.u_ctrl.u_asserts.fail_count);
		if (errors == 0 && u_dut.u_ctrl.u_asserts.fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * 50 * 40);
		$display("Timeout: the tests did not finish within the time limit");
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
hdl/issue_pkg.sv
hdl/instr_decoder.sv
hdl/operand_resolver.sv
hdl/issue_control.sv
hdl/issue_stage.sv
test/issue_asserts.sv
test/tb_issue_stage.sv
